//--- logic/axil_pkg.sv
// AXI4-Lite bus definitions
package axil_pkg;

  // ------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Response codes as carried on BRESP and RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Slave FSM, one transaction in flight
  typedef enum logic [2:0] {
    IDLE,
    RD_ACCESS,
    RD_RESP,
    WR_ACCESS,
    WR_RESP
  } slave_state_e;

endpackage

//--- logic/soc_map_pkg.sv
// SoC address map and debug hold-off
package soc_map_pkg;

  // ------------------------------------------------------------------
  // Region tags in address bits 31..28
  // ------------------------------------------------------------------
  localparam logic [3:0] TagRom  = 4'h1;
  localparam logic [3:0] TagExit = 4'h2;
  localparam logic [3:0] TagRam  = 4'h8;

  // Region sizes in 32-bit words
  localparam int unsigned RomWords      = 16;
  localparam int unsigned RamWords      = 256;
  localparam int unsigned RamIndexWidth = $clog2(RamWords);

  localparam logic [15:0] RomMarker = 16'hB007; // Upper half of every ROM word

  // Debug request blocked this many cycles after reset
  localparam int unsigned DebugHoldCycles = 24;
  localparam int unsigned HoldCntWidth    = $clog2(DebugHoldCycles + 1);

  // ------------------------------------------------------------------
  // Address word, decoded by region and by word
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [3:0]  tag;
    logic [27:0] offset;
  } region_view_t;

  typedef struct packed {
    logic [29-RamIndexWidth:0]  upper;
    logic [RamIndexWidth-1:0]   index; // Word within a region
    logic [1:0]                 lane;  // Byte within the word
  } word_view_t;

  typedef union packed {
    region_view_t region;
    word_view_t   word;
  } addr_word_u;

endpackage

//--- logic/mem_bus_if.sv
// Internal memory request bus
`timescale 1ns/1ps

interface mem_bus_if;

  // Request side, single-cycle pulse
  logic                    req;
  logic                    we;
  soc_map_pkg::addr_word_u addr;
  axil_pkg::data_t         wdata;
  axil_pkg::strb_t         strb;

  // Reply, exactly one cycle after req
  axil_pkg::data_t         rdata;
  axil_pkg::resp_e         resp;

  modport master (
    output req,
    output we,
    output addr,
    output wdata,
    output strb,
    input  rdata,
    input  resp
  );

  modport target (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  strb,
    output rdata,
    output resp
  );

endinterface

//--- logic/ram_store.sv
// Word RAM with byte strobes
`timescale 1ns/1ps

module ram_store (
  input  logic                                  clk_i,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [soc_map_pkg::RamIndexWidth-1:0] index_i,
  input  axil_pkg::data_t                       wdata_i,
  input  axil_pkg::strb_t                       strb_i,
  output axil_pkg::data_t                       rdata_o
);

  axil_pkg::data_t words_q [soc_map_pkg::RamWords];
  axil_pkg::data_t rdata_q;

  // Read is registered, a write returns the old word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= words_q[index_i];
      if (we_i) begin
        for (int i = 0; i < axil_pkg::StrbWidth; i++) begin
          if (strb_i[i]) begin
            words_q[index_i][8*i +: 8] <= wdata_i[8*i +: 8]; // Enabled lanes only
          end
        end
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- logic/debug_holdoff.sv
// Debug request hold-off after reset
`timescale 1ns/1ps

module debug_holdoff (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  logic [soc_map_pkg::HoldCntWidth-1:0] cnt_d;
  logic [soc_map_pkg::HoldCntWidth-1:0] cnt_q;

  // Count down, stop at zero
  assign cnt_d = (cnt_q != '0) ? cnt_q - 1'b1 : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_map_pkg::HoldCntWidth'(soc_map_pkg::DebugHoldCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign debug_req_o = (cnt_q == '0) && debug_en_i && debug_req_i;

  // Window only ever shrinks once out of reset
  a_cnt_no_inc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= $past(cnt_q));

endmodule

//--- logic/region_router.sv
// Address region router
`timescale 1ns/1ps

module region_router (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  mem_bus_if.target                            mem,
  // Word RAM
  output logic                                 ram_req_o,
  output logic                                 ram_we_o,
  output logic [soc_map_pkg::RamIndexWidth-1:0] ram_index_o,
  output axil_pkg::data_t                      ram_wdata_o,
  output axil_pkg::strb_t                      ram_strb_o,
  input  axil_pkg::data_t                      ram_rdata_i,
  // Exit code, held until the next exit write
  output axil_pkg::data_t                      exit_o
);

  logic            hit_rom;
  logic            hit_ram;
  logic            hit_exit;
  axil_pkg::resp_e resp_d;
  axil_pkg::resp_e resp_q;
  axil_pkg::data_t rdata_d;
  axil_pkg::data_t rdata_q;
  axil_pkg::data_t exit_q;
  logic            ram_rd_q; // Reply data comes from the RAM

  // ------------------------------------------------------------------
  // Region decode
  // ------------------------------------------------------------------
  assign hit_rom  = (mem.addr.region.tag == soc_map_pkg::TagRom) &&
                    (mem.addr.region.offset < 28'(soc_map_pkg::RomWords * 4));
  assign hit_ram  = (mem.addr.region.tag == soc_map_pkg::TagRam) &&
                    (mem.addr.region.offset < 28'(soc_map_pkg::RamWords * 4));
  assign hit_exit = (mem.addr.region.tag == soc_map_pkg::TagExit) &&
                    (mem.addr.region.offset == '0);

  always_comb begin
    resp_d  = axil_pkg::DECERR; // Unmapped space
    rdata_d = '0;
    if (hit_rom) begin
      if (mem.we) begin
        resp_d = axil_pkg::SLVERR;
      end else begin
        resp_d  = axil_pkg::OKAY;
        rdata_d = {soc_map_pkg::RomMarker, 8'h00, mem.addr.word.index};
      end
    end else if (hit_ram) begin
      resp_d = axil_pkg::OKAY;
    end else if (hit_exit) begin
      resp_d  = axil_pkg::OKAY;
      rdata_d = exit_q;
    end
  end

  // RAM access passes straight through
  assign ram_req_o   = mem.req && hit_ram;
  assign ram_we_o    = mem.we;
  assign ram_index_o = mem.addr.word.index;
  assign ram_wdata_o = mem.wdata;
  assign ram_strb_o  = mem.strb;

  // ------------------------------------------------------------------
  // Reply registers and exit code
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ram_rd_q <= 1'b0;
      resp_q   <= axil_pkg::OKAY;
      exit_q   <= '0;
    end else if (mem.req) begin
      ram_rd_q <= hit_ram && !mem.we;
      resp_q   <= resp_d;
      if (hit_exit && mem.we) begin
        exit_q <= mem.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign mem.rdata = ram_rd_q ? ram_rdata_i : rdata_q;
  assign mem.resp  = resp_q;
  assign exit_o    = exit_q;

  // In-range RAM access never answers with a decode error
  a_ram_no_decerr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.req && hit_ram |=> mem.resp != axil_pkg::DECERR);

endmodule

//--- logic/axil_slave_fsm.sv
// AXI4-Lite slave channel FSM
`timescale 1ns/1ps

module axil_slave_fsm (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Write address and data
  input  logic            awvalid_i,
  output logic            awready_o,
  input  axil_pkg::addr_t awaddr_i,
  input  logic            wvalid_i,
  output logic            wready_o,
  input  axil_pkg::data_t wdata_i,
  input  axil_pkg::strb_t wstrb_i,
  // Write response
  output logic            bvalid_o,
  input  logic            bready_i,
  output axil_pkg::resp_e bresp_o,
  // Read address
  input  logic            arvalid_i,
  output logic            arready_o,
  input  axil_pkg::addr_t araddr_i,
  // Read data
  output logic            rvalid_o,
  input  logic            rready_i,
  output axil_pkg::data_t rdata_o,
  output axil_pkg::resp_e rresp_o,
  // Towards the region router
  mem_bus_if.master       mem
);

  axil_pkg::slave_state_e state_d;
  axil_pkg::slave_state_e state_q;
  axil_pkg::addr_t        addr_q;
  axil_pkg::data_t        wdata_q;
  axil_pkg::strb_t        strb_q;
  axil_pkg::data_t        rdata_q;
  axil_pkg::resp_e        resp_q;
  axil_pkg::resp_e        resp_sel;
  logic                   ack_q;  // Router reply present this cycle
  logic                   aw_hs;

  // ------------------------------------------------------------------
  // Address handshakes, reads win in IDLE
  // ------------------------------------------------------------------
  assign arready_o = (state_q == axil_pkg::IDLE) && arvalid_i;
  assign aw_hs     = (state_q == axil_pkg::IDLE) && !arvalid_i && awvalid_i && wvalid_i;
  assign awready_o = aw_hs;
  assign wready_o  = aw_hs; // Rises together with awready

  always_comb begin
    state_d = state_q;
    case (state_q)
      axil_pkg::IDLE: begin
        if (arready_o) begin
          state_d = axil_pkg::RD_ACCESS;
        end else if (aw_hs) begin
          state_d = axil_pkg::WR_ACCESS;
        end
      end
      axil_pkg::RD_ACCESS: state_d = axil_pkg::RD_RESP;
      axil_pkg::WR_ACCESS: state_d = axil_pkg::WR_RESP;
      axil_pkg::RD_RESP:   if (rready_i) state_d = axil_pkg::IDLE;
      axil_pkg::WR_RESP:   if (bready_i) state_d = axil_pkg::IDLE;
      default:             state_d = axil_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= axil_pkg::IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= mem.req;
    end
  end

  // Request payload and held reply
  always_ff @(posedge clk_i) begin
    if (arready_o) begin
      addr_q <= araddr_i;
    end else if (aw_hs) begin
      addr_q  <= awaddr_i;
      wdata_q <= wdata_i;
      strb_q  <= wstrb_i;
    end
    if (ack_q) begin
      rdata_q <= mem.rdata;
      resp_q  <= mem.resp;
    end
  end

  // ------------------------------------------------------------------
  // Memory request and AXI responses
  // ------------------------------------------------------------------
  assign mem.req   = (state_q == axil_pkg::RD_ACCESS) || (state_q == axil_pkg::WR_ACCESS);
  assign mem.we    = (state_q == axil_pkg::WR_ACCESS);
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;
  assign mem.strb  = strb_q;

  assign resp_sel = ack_q ? mem.resp : resp_q; // Fresh reply first, then the held copy
  assign rdata_o  = ack_q ? mem.rdata : rdata_q;
  assign rresp_o  = resp_sel;
  assign bresp_o  = resp_sel;
  assign rvalid_o = (state_q == axil_pkg::RD_RESP);
  assign bvalid_o = (state_q == axil_pkg::WR_RESP);

  // Read reply held until taken
  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

  // Request only right after an address handshake, and only for one cycle
  a_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.req |-> $past(arready_o || aw_hs) ##1 !mem.req);

endmodule

//--- logic/soc_mem_top.sv
// SoC memory side top level
`timescale 1ns/1ps

module soc_mem_top (
  input  logic            clk_i,
  input  logic            rst_ni,
  // AXI4-Lite slave port
  input  logic            awvalid_i,
  output logic            awready_o,
  input  axil_pkg::addr_t awaddr_i,
  input  logic            wvalid_i,
  output logic            wready_o,
  input  axil_pkg::data_t wdata_i,
  input  axil_pkg::strb_t wstrb_i,
  output logic            bvalid_o,
  input  logic            bready_i,
  output axil_pkg::resp_e bresp_o,
  input  logic            arvalid_i,
  output logic            arready_o,
  input  axil_pkg::addr_t araddr_i,
  output logic            rvalid_o,
  input  logic            rready_i,
  output axil_pkg::data_t rdata_o,
  output axil_pkg::resp_e rresp_o,
  // Debug and exit
  input  logic            debug_req_i,
  input  logic            debug_en_i,
  output logic            debug_req_o,
  output axil_pkg::data_t exit_o
);

  logic                                  ram_req;
  logic                                  ram_we;
  logic [soc_map_pkg::RamIndexWidth-1:0] ram_index;
  axil_pkg::data_t                       ram_wdata;
  axil_pkg::strb_t                       ram_strb;
  axil_pkg::data_t                       ram_rdata;

  mem_bus_if mem_bus ();

  // ------------------------------------------------------------------
  // AXI4-Lite slave and address map
  // ------------------------------------------------------------------
  axil_slave_fsm i_axil_slave_fsm (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .awvalid_i ( awvalid_i ),
    .awready_o ( awready_o ),
    .awaddr_i  ( awaddr_i  ),
    .wvalid_i  ( wvalid_i  ),
    .wready_o  ( wready_o  ),
    .wdata_i   ( wdata_i   ),
    .wstrb_i   ( wstrb_i   ),
    .bvalid_o  ( bvalid_o  ),
    .bready_i  ( bready_i  ),
    .bresp_o   ( bresp_o   ),
    .arvalid_i ( arvalid_i ),
    .arready_o ( arready_o ),
    .araddr_i  ( araddr_i  ),
    .rvalid_o  ( rvalid_o  ),
    .rready_i  ( rready_i  ),
    .rdata_o   ( rdata_o   ),
    .rresp_o   ( rresp_o   ),
    .mem       ( mem_bus   )
  );

  region_router i_region_router (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .mem         ( mem_bus   ),
    .ram_req_o   ( ram_req   ),
    .ram_we_o    ( ram_we    ),
    .ram_index_o ( ram_index ),
    .ram_wdata_o ( ram_wdata ),
    .ram_strb_o  ( ram_strb  ),
    .ram_rdata_i ( ram_rdata ),
    .exit_o      ( exit_o    )
  );

  ram_store i_ram_store (
    .clk_i   ( clk_i     ),
    .req_i   ( ram_req   ),
    .we_i    ( ram_we    ),
    .index_i ( ram_index ),
    .wdata_i ( ram_wdata ),
    .strb_i  ( ram_strb  ),
    .rdata_o ( ram_rdata )
  );

  // Debug request gate
  debug_holdoff i_debug_holdoff (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- bench/tb_soc_mem_top.sv
// SoC memory side testbench
`timescale 1ns/1ps

module tb_soc_mem_top;

  logic            clk_i;
  logic            rst_ni;
  logic            awvalid_i;
  logic            awready_o;
  axil_pkg::addr_t awaddr_i;
  logic            wvalid_i;
  logic            wready_o;
  axil_pkg::data_t wdata_i;
  axil_pkg::strb_t wstrb_i;
  logic            bvalid_o;
  logic            bready_i;
  axil_pkg::resp_e bresp_o;
  logic            arvalid_i;
  logic            arready_o;
  axil_pkg::addr_t araddr_i;
  logic            rvalid_o;
  logic            rready_i;
  axil_pkg::data_t rdata_o;
  axil_pkg::resp_e rresp_o;
  logic            debug_req_i;
  logic            debug_en_i;
  logic            debug_req_o;
  axil_pkg::data_t exit_o;

  // Vectors as read from the golden file
  logic            vec_we   [$];
  axil_pkg::addr_t vec_addr [$];
  axil_pkg::data_t vec_data [$];
  axil_pkg::strb_t vec_strb [$];
  axil_pkg::data_t vec_exp  [$];
  axil_pkg::resp_e vec_resp [$];

  int cycles = 0;
  int limit  = 0; // Set once the vector count is known

  soc_mem_top uut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(input string name, input axil_pkg::data_t exp,
                            input axil_pkg::data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axil_pkg::resp_e exp,
                            input axil_pkg::resp_e act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail at %0t: %s expected %s, got %s", $time, name,
                              exp.name(), act.name()));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  // --------------------------------------------------------------------
  // AXI4-Lite driver, entered and left 1 ns after a rising edge
  // --------------------------------------------------------------------
  task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                            input axil_pkg::strb_t strb, output axil_pkg::resp_e resp);
    int unsigned delay;
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    do @(negedge clk_i); while (!(awready_o && wready_o));
    @(posedge clk_i);
    #1;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    delay = $urandom_range(3, 0); // Hold off bready
    repeat (delay) begin
      @(posedge clk_i);
      #1;
    end
    bready_i = 1'b1;
    do @(negedge clk_i); while (!bvalid_o);
    resp = bresp_o;
    @(posedge clk_i);
    #1;
    bready_i = 1'b0;
  endtask

  task automatic axil_read(input axil_pkg::addr_t addr, output axil_pkg::data_t data,
                           output axil_pkg::resp_e resp);
    int unsigned delay;
    arvalid_i = 1'b1;
    araddr_i  = addr;
    do @(negedge clk_i); while (!arready_o);
    @(posedge clk_i);
    #1;
    arvalid_i = 1'b0;
    delay = $urandom_range(3, 0); // Hold off rready
    repeat (delay) begin
      @(posedge clk_i);
      #1;
    end
    rready_i = 1'b1;
    do @(negedge clk_i); while (!rvalid_o);
    data = rdata_o;
    resp = rresp_o;
    @(posedge clk_i);
    #1;
    rready_i = 1'b0;
  endtask

  initial begin
    int              fd;
    int              n;
    string           line;
    logic [7:0]      op;
    axil_pkg::addr_t addr;
    axil_pkg::data_t data;
    axil_pkg::strb_t strb;
    axil_pkg::data_t exp_data;
    logic [1:0]      exp_raw;
    axil_pkg::data_t got_data;
    axil_pkg::resp_e got_resp;
    axil_pkg::data_t exp_exit;
    void'($urandom(32'h4f91));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    awvalid_i   = 1'b0;
    awaddr_i    = '0;
    wvalid_i    = 1'b0;
    wdata_i     = '0;
    wstrb_i     = '0;
    bready_i    = 1'b0;
    arvalid_i   = 1'b0;
    araddr_i    = '0;
    rready_i    = 1'b0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;

    fd = $fopen("bench/golden_vectors.txt", "r");
    if (fd == 0) begin
      stop_on_error("Could not open the golden vector file bench/golden_vectors.txt");
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, exp_data, exp_raw);
      if (n == 6 && (op == "R" || op == "W")) begin // Comment lines fall out here
        vec_we.push_back(op == "W");
        vec_addr.push_back(addr);
        vec_data.push_back(data);
        vec_strb.push_back(strb);
        vec_exp.push_back(exp_data);
        vec_resp.push_back(axil_pkg::resp_e'(exp_raw));
      end
    end
    $fclose(fd);
    limit = 20 * vec_addr.size() + 100;

    // Reset, all channels quiet
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("arready_o", 1'b0, arready_o);
    check_bit("awready_o", 1'b0, awready_o);
    check_bit("wready_o", 1'b0, wready_o);
    check_bit("rvalid_o", 1'b0, rvalid_o);
    check_bit("bvalid_o", 1'b0, bvalid_o);
    check_bit("debug_req_o", 1'b0, debug_req_o);
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Debug hold-off window, as seen at each edge after reset release
    for (int k = 1; k <= int'(soc_map_pkg::DebugHoldCycles) + 1; k++) begin
      @(negedge clk_i);
      check_bit("debug_req_o", k > int'(soc_map_pkg::DebugHoldCycles), debug_req_o);
    end
    @(posedge clk_i);
    #1;
    debug_en_i = 1'b0;
    @(negedge clk_i);
    check_bit("debug_req_o", 1'b0, debug_req_o);

    // --------------------------------------------------------------------
    // Golden transactions in file order
    // --------------------------------------------------------------------
    exp_exit = '0;
    check_data("exit_o", exp_exit, exit_o);
    @(posedge clk_i);
    #1;
    for (int i = 0; i < vec_addr.size(); i++) begin
      if (vec_we[i]) begin
        axil_write(vec_addr[i], vec_data[i], vec_strb[i], got_resp);
        check_resp("bresp_o", vec_resp[i], got_resp);
        // Exit register sits at offset zero of its region
        if (vec_addr[i][31:28] == soc_map_pkg::TagExit && vec_addr[i][27:0] == '0) begin
          exp_exit = vec_data[i];
        end
      end else begin
        axil_read(vec_addr[i], got_data, got_resp);
        check_resp("rresp_o", vec_resp[i], got_resp);
        check_data("rdata_o", vec_exp[i], got_data);
      end
      check_data("exit_o", exp_exit, exit_o);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- soc_mem_top.f
logic/axil_pkg.sv
logic/soc_map_pkg.sv
logic/mem_bus_if.sv
logic/ram_store.sv
logic/debug_holdoff.sv
logic/region_router.sv
logic/axil_slave_fsm.sv
logic/soc_mem_top.sv
bench/tb_soc_mem_top.sv

//--- Makefile
TOP  := tb_soc_mem_top
SRCS := $(shell cat soc_mem_top.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): soc_mem_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f soc_mem_top.f

run: obj_dir/V$(TOP) bench/golden_vectors.txt
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log; grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/golden_vectors.txt
# op addr data strb exp_data exp_resp  (all hex after op, W = write, R = read)
# resp 0 = OKAY, 2 = SLVERR, 3 = DECERR, exp_data unused for writes
R 10000000 00000000 0 B0070000 0
R 10000004 00000000 0 B0070001 0
R 1000003C 00000000 0 B007000F 0
W 10000008 DEADBEEF F 00000000 2
R 10000008 00000000 0 B0070002 0
W 80000000 11223344 F 00000000 0
W 80000004 AABBCCDD F 00000000 0
W 800003FC 01020304 F 00000000 0
W 80000000 000000EE 1 00000000 0
W 80000004 99880000 C 00000000 0
W 800003FC 0000FF00 2 00000000 0
R 80000000 00000000 0 112233EE 0
R 80000004 00000000 0 9988CCDD 0
R 800003FC 00000000 0 0102FF04 0
R 30000000 00000000 0 00000000 3
R 80000400 00000000 0 00000000 3
W 80000400 12345678 F 00000000 3
R 20000004 00000000 0 00000000 3
W 20000004 12345678 F 00000000 3
R 10000040 00000000 0 00000000 3
W 20000000 CAFE0001 F 00000000 0
R 20000000 00000000 0 CAFE0001 0
W 80000008 55667788 F 00000000 0
W 80000008 00AA0000 4 00000000 0
R 80000008 00000000 0 55AA7788 0
R 20000000 00000000 0 CAFE0001 0
R 80000000 00000000 0 112233EE 0
